/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_krv_e
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_krv_e.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module tb_krv_e;

	localparam int          CLK_PERIOD  = 10;
	localparam logic [31:0] LFSR_SEED   = 32'h4f62_ee3a;
	localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
	localparam int          N_DTCM      = 64;
	localparam int          TIMER_GAP   = 17;
	localparam int          N_REQ       = 2 * N_DTCM + 16;
	localparam int          TIMER_WAIT  = TIMER_GAP + 25;
	localparam int          WATCHDOG_NS = (N_REQ + TIMER_WAIT + 100) * CLK_PERIOD;

	logic        clk_in;
	logic        rst;
	logic        req_valid;
	logic        req_wr;
	logic [31:0] req_addr;
	logic [3:0]  req_strb;
	logic [31:0] req_wdata;
	logic        rsp_valid;
	logic [31:0] rsp_rdata;
	logic        rsp_err;
	logic [7:0]  gpio_in;
	logic [7:0]  gpio_out;
	logic        timer_int;

	int          cyc = 0;
	logic [31:0] lfsr = LFSR_SEED;
	logic [31:0] last_rdata;

	// expected responses in request order
	int          exp_due[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_mask[$];
	logic        exp_err[$];

	// byte model of the DTCM with a mask of known bytes
	logic [7:0]  model_mem [0:4*`KRV_DTCM_WORDS-1];
	bit          model_ok [0:4*`KRV_DTCM_WORDS-1];
	logic [31:0] waddr [N_DTCM];
	int          widx [N_DTCM];

	krv_e u_dut (
		.clk_in    (clk_in),
		.rst       (rst),
		.req_valid (req_valid),
		.req_wr    (req_wr),
		.req_addr  (req_addr),
		.req_strb  (req_strb),
		.req_wdata (req_wdata),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.rsp_err   (rsp_err),
		.gpio_in   (gpio_in),
		.gpio_out  (gpio_out),
		.timer_int (timer_int)
	);

	initial begin
		clk_in = 1'b0;
		forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
	end

	always @(posedge clk_in) begin
		cyc <= cyc + 1;
	end

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
			abort_run();
		end
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
		end
		return r;
	endfunction

	function automatic logic [31:0] model_word(input int idx);
		logic [31:0] r;
		for (int b = 0; b < 4; b++) begin
			r[8*b +: 8] = model_mem[4*idx + b];
		end
		return r;
	endfunction

	function automatic logic [31:0] model_mask(input int idx);
		logic [31:0] r;
		for (int b = 0; b < 4; b++) begin
			r[8*b +: 8] = model_ok[4*idx + b] ? 8'hff : 8'h00;
		end
		return r;
	endfunction

	// entered and left one step after a rising edge
	task automatic issue(input logic wr, input logic [31:0] addr, input logic [3:0] strb,
			input logic [31:0] wdata, input logic [31:0] data, input logic [31:0] mask,
			input logic err);
		req_valid = 1'b1;
		req_wr    = wr;
		req_addr  = addr;
		req_strb  = strb;
		req_wdata = wdata;
		exp_due.push_back(cyc + 2);
		exp_data.push_back(data);
		exp_mask.push_back(mask);
		exp_err.push_back(err);
		@(posedge clk_in);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_in);
		#1;
	endtask

	task automatic drain();
		while (exp_due.size() != 0) begin
			idle(1);
		end
	endtask

	// response monitor sampled mid cycle
	always @(negedge clk_in) begin
		if (!rst) begin
			if (rsp_valid === 1'b1) begin
				if (exp_due.size() == 0) begin
					$display("unexpected response with no request outstanding, cycle %0d", cyc);
					abort_run();
				end else begin
					check("rsp_cycle", 32'(cyc), 32'(exp_due[0]));
					check("rsp_err", 32'(rsp_err), 32'(exp_err[0]));
					check("rsp_rdata", rsp_rdata & exp_mask[0], exp_data[0] & exp_mask[0]);
					last_rdata = rsp_rdata;
					void'(exp_due.pop_front());
					void'(exp_data.pop_front());
					void'(exp_mask.pop_front());
					void'(exp_err.pop_front());
				end
			end else if (exp_due.size() != 0 && cyc >= exp_due[0]) begin
				$display("missing response, one was due at cycle %0d", exp_due[0]);
				abort_run();
			end
		end
	end

	task automatic test_reset();
		idle(1);
		check("rsp_valid", 32'(rsp_valid), 32'h0);
		check("rsp_err", 32'(rsp_err), 32'h0);
		check("timer_int", 32'(timer_int), 32'h0);
		check("gpio_out", 32'(gpio_out), 32'h0);
	endtask

	task automatic test_dtcm();
		logic [31:0] w;
		logic [31:0] data;
		logic [3:0]  strb;
		for (int i = 0; i < N_DTCM; i++) begin
			w = rand_bits(14);
			data = rand_bits(32);
			strb = 4'(rand_bits(4));
			widx[i] = int'(w % `KRV_DTCM_WORDS);
			waddr[i] = `KRV_DTCM_BASE | (w << 2);
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					model_mem[4*widx[i] + b] = data[8*b +: 8];
					model_ok[4*widx[i] + b] = 1'b1;
				end
			end
			issue(1'b1, waddr[i], strb, data, 32'h0, 32'hffff_ffff, 1'b0);
		end
		for (int i = 0; i < N_DTCM; i++) begin
			issue(1'b0, waddr[i], 4'h0, 32'h0, model_word(widx[i]), model_mask(widx[i]), 1'b0);
		end
		drain();
	endtask

	task automatic test_unmapped();
		// same offset as a DTCM word in an empty region
		issue(1'b1, 32'h0002_0000 | {16'h0, waddr[0][15:0]}, 4'hf, rand_bits(32),
			32'h0, 32'hffff_ffff, 1'b1);
		issue(1'b0, 32'h3000_0004, 4'h0, 32'h0, 32'h0, 32'hffff_ffff, 1'b1);
		issue(1'b1, 32'hffff_fffc, 4'hf, rand_bits(32), 32'h0, 32'hffff_ffff, 1'b1);
		issue(1'b0, 32'h0000_0010, 4'h0, 32'h0, 32'h0, 32'hffff_ffff, 1'b1);
		issue(1'b0, waddr[0], 4'h0, 32'h0, model_word(widx[0]), model_mask(widx[0]), 1'b0);
		drain();
	endtask

	task automatic test_gpio();
		logic [7:0] v;
		v = 8'(rand_bits(8));
		issue(1'b1, `KRV_GPIO_BASE | `KRV_GPIO_OUT_OFS, 4'b0001, {24'h0, v},
			32'h0, 32'hffff_ffff, 1'b0);
		drain();
		check("gpio_out", 32'(gpio_out), 32'(v));
		issue(1'b0, `KRV_GPIO_BASE | `KRV_GPIO_OUT_OFS, 4'h0, 32'h0, {24'h0, v},
			32'hffff_ffff, 1'b0);
		drain();
		v = 8'(rand_bits(8));
		gpio_in = v;
		idle(4);
		issue(1'b0, `KRV_GPIO_BASE | `KRV_GPIO_IN_OFS, 4'h0, 32'h0, {24'h0, v},
			32'hffff_ffff, 1'b0);
		drain();
	endtask

	task automatic test_timer();
		int          c1;
		int          c2;
		int          c_wr;
		logic [31:0] v1;
		logic [31:0] v2;
		c1 = cyc;
		issue(1'b0, `KRV_TIMER_BASE | `KRV_MTIME_OFS, 4'h0, 32'h0, 32'h0, 32'h0, 1'b0);
		drain();
		v1 = last_rdata;
		idle(TIMER_GAP);
		c2 = cyc;
		issue(1'b0, `KRV_TIMER_BASE | `KRV_MTIME_OFS, 4'h0, 32'h0, 32'h0, 32'h0, 1'b0);
		drain();
		v2 = last_rdata;
		check("mtime_delta", v2 - v1, 32'(c2 - c1));

		// compare point 20 ticks past a fresh reading
		issue(1'b0, `KRV_TIMER_BASE | `KRV_MTIME_OFS, 4'h0, 32'h0, 32'h0, 32'h0, 1'b0);
		drain();
		v1 = last_rdata + 32'd20;
		c_wr = cyc;
		issue(1'b1, `KRV_TIMER_BASE | `KRV_MTIMECMP_OFS, 4'hf, v1, 32'h0, 32'hffff_ffff, 1'b0);
		drain();
		check("timer_int", 32'(timer_int), 32'h0);
		issue(1'b0, `KRV_TIMER_BASE | `KRV_MTIMECMP_OFS, 4'h0, 32'h0, v1, 32'hffff_ffff, 1'b0);
		while (timer_int !== 1'b1 && cyc < c_wr + 25) begin
			idle(1);
		end
		check("timer_int", 32'(timer_int), 32'h1);
		drain();

		issue(1'b1, `KRV_TIMER_BASE | `KRV_MTIMECMP_OFS, 4'hf, 32'hffff_ffff,
			32'h0, 32'hffff_ffff, 1'b0);
		drain();
		idle(1);
		check("timer_int", 32'(timer_int), 32'h0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		rst       = 1'b1;
		req_valid = 1'b0;
		req_wr    = 1'b0;
		req_addr  = '0;
		req_strb  = '0;
		req_wdata = '0;
		gpio_in   = '0;
		repeat (8) @(posedge clk_in);
		#1;
		rst = 1'b0;
		test_reset();
		test_dtcm();
		test_unmapped();
		test_gpio();
		test_timer();
		$display("** PASS **");
		$finish;
	end

endmodule

/* tb.f */
+incdir+verilog
verilog/krv_pkg.sv
verilog/periph_bus_if.sv
verilog/addr_decoder.sv
verilog/dtcm.sv
verilog/core_timer.sv
verilog/gpio.sv
verilog/rsp_mux.sv
verilog/krv_e.sv
dv/tb_krv_e.sv

/* verilog/addr_decoder.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module addr_decoder (
	input  logic                       clk_in,
	input  logic                       rst,
	input  logic                       req_valid,
	input  logic                       req_wr,
	input  logic [`KRV_ADDR_WIDTH-1:0] req_addr,
	input  logic [`KRV_STRB_WIDTH-1:0] req_strb,
	input  logic [`KRV_DATA_WIDTH-1:0] req_wdata,
	periph_bus_if.decoder              bus
);
	import krv_pkg::*;

	logic [`KRV_ADDR_WIDTH-1:0] region;
	slave_sel_e                 sel_d;
	bus_op_e                    op_d;

	assign region = req_addr & `KRV_REGION_MASK;
	assign op_d = req_wr ? OP_WRITE : OP_READ;

	// region compare, anything unmapped falls to SEL_NONE
	always_comb begin
		case (region)
			`KRV_DTCM_BASE: begin
				sel_d = SEL_DTCM;
			end
			`KRV_TIMER_BASE: begin
				sel_d = SEL_TIMER;
			end
			`KRV_GPIO_BASE: begin
				sel_d = SEL_GPIO;
			end
			default: begin
				sel_d = SEL_NONE;
			end
		endcase
	end

	// request strobe, one cycle behind the top-level port
	always_ff @(posedge clk_in) begin
		if (rst) begin
			bus.valid <= 1'b0;
		end else begin
			bus.valid <= req_valid;
		end
	end

	// payload only moves with a request
	always_ff @(posedge clk_in) begin
		if (req_valid) begin
			bus.sel    <= sel_d;
			bus.op     <= op_d;
			bus.offset <= req_addr[`KRV_OFFSET_WIDTH-1:0];
			bus.strb   <= req_strb;
			bus.wdata  <= req_wdata;
		end
	end

endmodule

/* verilog/core_timer.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module core_timer (
	input  logic                       clk_in,
	input  logic                       rst,
	periph_bus_if.slave                bus,
	output logic [`KRV_DATA_WIDTH-1:0] rdata,
	output logic                       timer_int
);
	import krv_pkg::*;

	logic [`KRV_DATA_WIDTH-1:0] mtime;
	logic [`KRV_DATA_WIDTH-1:0] mtimecmp;
	logic                       hit;
	logic                       at_mtime;
	logic                       at_cmp;
	logic                       wr_mtime;
	logic                       wr_cmp;
	logic                       rd_en;

	// strobed byte merge of wdata into a register
	function automatic logic [`KRV_DATA_WIDTH-1:0] merge(
		input logic [`KRV_DATA_WIDTH-1:0] old_val,
		input logic [`KRV_DATA_WIDTH-1:0] new_val,
		input logic [`KRV_STRB_WIDTH-1:0] strb
	);
		logic [`KRV_DATA_WIDTH-1:0] res;
		res = old_val;
		for (int i = 0; i < `KRV_STRB_WIDTH; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_val[8*i +: 8];
			end
		end
		return res;
	endfunction

	assign hit = bus.valid && (bus.sel == SEL_TIMER);
	assign at_mtime = (bus.offset == `KRV_OFFSET_WIDTH'(`KRV_MTIME_OFS));
	assign at_cmp = (bus.offset == `KRV_OFFSET_WIDTH'(`KRV_MTIMECMP_OFS));
	assign wr_mtime = hit && (bus.op == OP_WRITE) && at_mtime;
	assign wr_cmp = hit && (bus.op == OP_WRITE) && at_cmp;
	assign rd_en = hit && (bus.op == OP_READ);

	// free running, a write replaces this cycle's increment
	always_ff @(posedge clk_in) begin
		if (rst) begin
			mtime <= '0;
		end else if (wr_mtime) begin
			mtime <= merge(mtime, bus.wdata, bus.strb);
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	// all ones keeps the interrupt quiet out of reset
	always_ff @(posedge clk_in) begin
		if (rst) begin
			mtimecmp <= '1;
			timer_int <= 1'b0;
		end else begin
			if (wr_cmp) begin
				mtimecmp <= merge(mtimecmp, bus.wdata, bus.strb);
			end
			timer_int <= (mtime >= mtimecmp);
		end
	end

	// value sampled at the edge the request arrives
	always_ff @(posedge clk_in) begin
		if (rd_en && at_mtime) begin
			rdata <= mtime;
		end else if (rd_en && at_cmp) begin
			rdata <= mtimecmp;
		end else begin
			rdata <= '0;
		end
	end

endmodule

/* verilog/dtcm.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module dtcm #(
	parameter int DEPTH = `KRV_DTCM_WORDS
) (
	input  logic                       clk_in,
	periph_bus_if.slave                bus,
	output logic [`KRV_DATA_WIDTH-1:0] rdata
);
	import krv_pkg::*;

	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [`KRV_DATA_WIDTH-1:0] mem [DEPTH];
	logic [IDX_W-1:0]           idx;
	logic                       hit;
	logic                       wr_en;
	logic                       rd_en;

	assign hit = bus.valid && (bus.sel == SEL_DTCM);
	assign wr_en = hit && (bus.op == OP_WRITE);
	assign rd_en = hit && (bus.op == OP_READ);

	// word index, wraps around the array
	assign idx = IDX_W'((bus.offset >> 2) % DEPTH);

	// byte lanes are written independently
	always_ff @(posedge clk_in) begin
		if (wr_en) begin
			for (int i = 0; i < `KRV_STRB_WIDTH; i++) begin
				if (bus.strb[i]) begin
					mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
	end

	// zero unless this cycle is our read
	always_ff @(posedge clk_in) begin
		if (rd_en) begin
			rdata <= mem[idx];
		end else begin
			rdata <= '0;
		end
	end

endmodule

/* verilog/gpio.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module gpio (
	input  logic                       clk_in,
	input  logic                       rst,
	periph_bus_if.slave                bus,
	input  logic [`KRV_GPIO_WIDTH-1:0] gpio_in,
	output logic [`KRV_GPIO_WIDTH-1:0] gpio_out,
	output logic [`KRV_DATA_WIDTH-1:0] rdata
);
	import krv_pkg::*;

	logic [`KRV_GPIO_WIDTH-1:0] in_meta;
	logic [`KRV_GPIO_WIDTH-1:0] in_sync;
	logic                       hit;
	logic                       at_out;
	logic                       at_in;
	logic                       rd_en;

	assign hit = bus.valid && (bus.sel == SEL_GPIO);
	assign at_out = (bus.offset == `KRV_OFFSET_WIDTH'(`KRV_GPIO_OUT_OFS));
	assign at_in = (bus.offset == `KRV_OFFSET_WIDTH'(`KRV_GPIO_IN_OFS));
	assign rd_en = hit && (bus.op == OP_READ);

	// output pins take byte lane 0 only
	always_ff @(posedge clk_in) begin
		if (rst) begin
			gpio_out <= '0;
		end else if (hit && (bus.op == OP_WRITE) && at_out && bus.strb[0]) begin
			gpio_out <= bus.wdata[`KRV_GPIO_WIDTH-1:0];
		end
	end

	// two-flop synchroniser on the async pins
	always_ff @(posedge clk_in) begin
		if (rst) begin
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			in_meta <= gpio_in;
			in_sync <= in_meta;
		end
	end

	always_ff @(posedge clk_in) begin
		if (rd_en && at_out) begin
			rdata <= `KRV_DATA_WIDTH'(gpio_out);
		end else if (rd_en && at_in) begin
			rdata <= `KRV_DATA_WIDTH'(in_sync);
		end else begin
			rdata <= '0;
		end
	end

endmodule

/* verilog/krv_e.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module krv_e (
	input  logic                       clk_in,
	input  logic                       rst,

	// data port, one request per strobe
	input  logic                       req_valid,
	input  logic                       req_wr,
	input  logic [`KRV_ADDR_WIDTH-1:0] req_addr,
	input  logic [`KRV_STRB_WIDTH-1:0] req_strb,
	input  logic [`KRV_DATA_WIDTH-1:0] req_wdata,

	// response, two cycles behind the request
	output logic                       rsp_valid,
	output logic [`KRV_DATA_WIDTH-1:0] rsp_rdata,
	output logic                       rsp_err,

	input  logic [`KRV_GPIO_WIDTH-1:0] gpio_in,
	output logic [`KRV_GPIO_WIDTH-1:0] gpio_out,
	output logic                       timer_int
);

	logic [`KRV_DATA_WIDTH-1:0] dtcm_rdata;
	logic [`KRV_DATA_WIDTH-1:0] timer_rdata;
	logic [`KRV_DATA_WIDTH-1:0] gpio_rdata;

	periph_bus_if bus ();

	// decode stage
	addr_decoder u_addr_decoder (
		.clk_in    (clk_in),
		.rst       (rst),
		.req_valid (req_valid),
		.req_wr    (req_wr),
		.req_addr  (req_addr),
		.req_strb  (req_strb),
		.req_wdata (req_wdata),
		.bus       (bus)
	);

	// slaves
	dtcm #(
		.DEPTH (`KRV_DTCM_WORDS)
	) u_dtcm (
		.clk_in (clk_in),
		.bus    (bus),
		.rdata  (dtcm_rdata)
	);

	core_timer u_core_timer (
		.clk_in    (clk_in),
		.rst       (rst),
		.bus       (bus),
		.rdata     (timer_rdata),
		.timer_int (timer_int)
	);

	gpio u_gpio (
		.clk_in   (clk_in),
		.rst      (rst),
		.bus      (bus),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.rdata    (gpio_rdata)
	);

	// result stage
	rsp_mux u_rsp_mux (
		.clk_in      (clk_in),
		.rst         (rst),
		.bus         (bus),
		.dtcm_rdata  (dtcm_rdata),
		.timer_rdata (timer_rdata),
		.gpio_rdata  (gpio_rdata),
		.rsp_valid   (rsp_valid),
		.rsp_rdata   (rsp_rdata),
		.rsp_err     (rsp_err)
	);

endmodule

/* verilog/krv_params.svh */
`ifndef KRV_PARAMS_SVH
`define KRV_PARAMS_SVH

// bus widths
`define KRV_DATA_WIDTH 32
`define KRV_ADDR_WIDTH 32
`define KRV_STRB_WIDTH 4

// address bits below the region select
`define KRV_OFFSET_WIDTH 16
`define KRV_REGION_MASK (~((32'h1 << `KRV_OFFSET_WIDTH) - 32'h1))

// slave region bases
`define KRV_DTCM_BASE 32'h0001_0000
`define KRV_TIMER_BASE 32'h0200_0000
`define KRV_GPIO_BASE 32'h1000_0000

`define KRV_DTCM_WORDS 256
`define KRV_GPIO_WIDTH 8

// register offsets inside a region
`define KRV_MTIME_OFS 32'h0000_0000
`define KRV_MTIMECMP_OFS 32'h0000_0004
`define KRV_GPIO_OUT_OFS 32'h0000_0000
`define KRV_GPIO_IN_OFS 32'h0000_0004

`endif

/* verilog/krv_pkg.sv */
package krv_pkg;

	// target of a decoded request
	// SEL_NONE doubles as the decode error
	typedef enum logic [1:0] {
		SEL_NONE  = 2'd0,
		SEL_DTCM  = 2'd1,
		SEL_TIMER = 2'd2,
		SEL_GPIO  = 2'd3
	} slave_sel_e;

	// direction of a bus request
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

endpackage

/* verilog/periph_bus_if.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

interface periph_bus_if;
	import krv_pkg::*;

	// one-cycle strobe, qualifies everything below
	logic                         valid;
	slave_sel_e                   sel;
	bus_op_e                      op;
	// byte address inside the selected region
	logic [`KRV_OFFSET_WIDTH-1:0] offset;
	logic [`KRV_STRB_WIDTH-1:0]   strb;
	logic [`KRV_DATA_WIDTH-1:0]   wdata;

	modport decoder (
		output valid,
		output sel,
		output op,
		output offset,
		output strb,
		output wdata
	);

	modport slave (
		input valid,
		input sel,
		input op,
		input offset,
		input strb,
		input wdata
	);

endinterface

/* verilog/rsp_mux.sv */
`timescale 1ns/1ps
`include "krv_params.svh"

module rsp_mux (
	input  logic                       clk_in,
	input  logic                       rst,
	periph_bus_if.slave                bus,
	input  logic [`KRV_DATA_WIDTH-1:0] dtcm_rdata,
	input  logic [`KRV_DATA_WIDTH-1:0] timer_rdata,
	input  logic [`KRV_DATA_WIDTH-1:0] gpio_rdata,
	output logic                       rsp_valid,
	output logic [`KRV_DATA_WIDTH-1:0] rsp_rdata,
	output logic                       rsp_err
);
	import krv_pkg::*;

	logic       valid_q;
	slave_sel_e sel_q;

	// same edge the slaves register their read data
	always_ff @(posedge clk_in) begin
		if (rst) begin
			valid_q <= 1'b0;
			sel_q   <= SEL_NONE;
		end else begin
			valid_q <= bus.valid;
			sel_q   <= bus.sel;
		end
	end

	assign rsp_valid = valid_q;
	assign rsp_err = valid_q && (sel_q == SEL_NONE);

	// slaves already return zero for writes
	always_comb begin
		rsp_rdata = '0;
		if (valid_q) begin
			case (sel_q)
				SEL_DTCM:  rsp_rdata = dtcm_rdata;
				SEL_TIMER: rsp_rdata = timer_rdata;
				SEL_GPIO:  rsp_rdata = gpio_rdata;
				default:   rsp_rdata = '0;
			endcase
		end
	end

endmodule
